// File: hw/pwm_pkg.sv
/*
 * PWM timer shared definitions
 * Bus widths, register map, control bit positions, channel config
 */
`default_nettype none

package pwm_pkg;

  // ==================================================
  // Bus and register map
  // ==================================================
  localparam int DATA_W    = 32;  // Wishbone data width
  localparam int ADDR_W    = 6;   // Word address width
  localparam int CH_BASE   = 16;  // First channel word
  localparam int CH_STRIDE = 2;   // Words per channel
  localparam int MAX_W     = 16;  // Widest timer field

  typedef enum logic [ADDR_W-1:0] {
    REG_GCR      = 6'd0,
    REG_PERIOD   = 6'd1,
    REG_PSC      = 6'd2,
    REG_CNT      = 6'd3,  // Read only
    REG_DEADTIME = 6'd4,  // Rise low half, fall high half
    REG_IER      = 6'd5,
    REG_ISR      = 6'd6   // Write 1 to clear
  } reg_addr_e;

  // Word offset inside one channel
  typedef enum logic [ADDR_W-1:0] {
    CH_CCR  = 6'd0,
    CH_DUTY = 6'd1
  } ch_reg_e;

  // ==================================================
  // Bit positions
  // ==================================================
  localparam int GCR_EN     = 0;  // Counter run
  localparam int GCR_OUTEN  = 1;  // Master output gate
  localparam int CCR_EN     = 0;
  localparam int CCR_POL    = 1;  // Active low
  localparam int CCR_COMPEN = 2;  // Complement output
  localparam int CCR_DTEN   = 3;  // Dead-time insertion
  localparam int ISR_PERIOD = 0;

  // One channel's config as seen by the channel
  typedef struct packed {
    logic             en;
    logic             pol;
    logic             comp_en;
    logic             dt_en;
    logic [MAX_W-1:0] duty;
  } ch_cfg_t;

  // Dead-time FSM states
  typedef enum logic [1:0] {
    DT_OFF,
    DT_RISE,
    DT_ON,
    DT_FALL
  } dt_state_e;

endpackage

`default_nettype wire

// File: hw/pwm_timer_if.sv
/*
 * PWM timebase link
 * Counter controls down from the registers, tick and count back up
 */
`timescale 1ns/1ns
`default_nettype none

interface pwm_timer_if #(
  parameter int PWM_WIDTH = 16
);

  logic                 en;      // Run, counter frozen at 0 when low
  logic [PWM_WIDTH-1:0] period;  // Counts per period
  logic [PWM_WIDTH-1:0] psc;     // Prescale divide minus one
  logic                 tick;    // Prescaled count enable
  logic [PWM_WIDTH-1:0] cnt;     // Period counter
  logic                 wrap;    // Last tick of a period

  // Register block side
  modport ctrl (output en, output period, output psc, input cnt, input wrap);

  // Timebase side
  modport tb (input en, input period, input psc, output tick, output cnt, output wrap);

  // Channel side
  modport chan (input tick, input cnt);

endinterface

`default_nettype wire

// File: hw/pwm_regs.sv
/*
 * PWM register block
 * Wishbone classic slave, global and per-channel registers,
 * read mux and period interrupt status
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_regs #(
  parameter int NUM_CHANNELS = 8,
  parameter int PWM_WIDTH    = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [pwm_pkg::ADDR_W-1:0] adr_i,
  input  logic [pwm_pkg::DATA_W-1:0] dat_i,
  output logic [pwm_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic                       irq_o,
  pwm_timer_if.ctrl                  tmr,
  output pwm_pkg::ch_cfg_t           ch_cfg_o [NUM_CHANNELS],
  output logic [PWM_WIDTH-1:0]       dt_rise_o,
  output logic [PWM_WIDTH-1:0]       dt_fall_o,
  output logic                       out_en_o
);
  import pwm_pkg::*;

  localparam int DT_FALL_LSB = 16;  // Fall time field in DEADTIME

  // ==================================================
  // Register state
  // ==================================================
  logic [GCR_OUTEN:0]   gcr_q;
  logic [PWM_WIDTH-1:0] period_q;
  logic [PWM_WIDTH-1:0] psc_q;
  logic [PWM_WIDTH-1:0] dt_rise_q;
  logic [PWM_WIDTH-1:0] dt_fall_q;
  logic                 ier_q;    // Period irq enable
  logic                 isr_q;    // Period irq pending
  logic [CCR_DTEN:0]    ccr_q  [NUM_CHANNELS];
  logic [PWM_WIDTH-1:0] duty_q [NUM_CHANNELS];

  logic                 access;   // Request not yet acked
  logic                 wr_en;
  reg_addr_e            reg_addr;
  logic [ADDR_W-1:0]    ch_off;   // Words past channel base
  logic [ADDR_W-1:0]    ch_idx;
  ch_reg_e              ch_reg;
  logic                 ch_hit;   // Address lands in a channel
  logic [DATA_W-1:0]    rd_data;

  // ==================================================
  // Address decode
  // ==================================================
  assign access   = cyc_i && stb_i && !ack_o;  // One ack per two cycles when held
  assign wr_en    = access && we_i;
  assign reg_addr = reg_addr_e'(adr_i);
  assign ch_off   = adr_i - ADDR_W'(CH_BASE);
  assign ch_idx   = ch_off / ADDR_W'(CH_STRIDE);
  assign ch_reg   = ch_reg_e'(ch_off % ADDR_W'(CH_STRIDE));
  assign ch_hit   = (adr_i >= ADDR_W'(CH_BASE)) && (ch_idx < NUM_CHANNELS);

  // Register writes, full words only
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      gcr_q     <= '0;
      period_q  <= '1;  // Longest period out of reset
      psc_q     <= '0;
      dt_rise_q <= '0;
      dt_fall_q <= '0;
      ier_q     <= 1'b0;
      isr_q     <= 1'b0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        ccr_q[i]  <= '0;
        duty_q[i] <= '0;
      end
    end else begin
      if (wr_en) begin
        case (reg_addr)
          REG_GCR:      gcr_q    <= dat_i[GCR_OUTEN:0];
          REG_PERIOD:   period_q <= dat_i[PWM_WIDTH-1:0];
          REG_PSC:      psc_q    <= dat_i[PWM_WIDTH-1:0];
          REG_CNT:      ;  // Counter not writable
          REG_DEADTIME: begin
            dt_rise_q <= dat_i[PWM_WIDTH-1:0];
            dt_fall_q <= dat_i[DT_FALL_LSB +: PWM_WIDTH];
          end
          REG_IER:      ier_q <= dat_i[ISR_PERIOD];
          REG_ISR:      if (dat_i[ISR_PERIOD]) isr_q <= 1'b0;  // W1C
          default: begin
            // Channel words, anything else dropped
            for (int i = 0; i < NUM_CHANNELS; i++) begin
              if (ch_hit && (ch_idx == ADDR_W'(i))) begin
                case (ch_reg)
                  CH_CCR:  ccr_q[i]  <= dat_i[CCR_DTEN:0];
                  CH_DUTY: duty_q[i] <= dat_i[PWM_WIDTH-1:0];
                  default: ;
                endcase
              end
            end
          end
        endcase
      end
      if (tmr.wrap) begin
        isr_q <= 1'b1;  // Set wins over a same-cycle clear
      end
    end
  end

  // ==================================================
  // Read path
  // ==================================================
  always_comb begin
    rd_data = '0;  // Unknown words read zero
    case (reg_addr)
      REG_GCR:      rd_data = DATA_W'(gcr_q);
      REG_PERIOD:   rd_data = DATA_W'(period_q);
      REG_PSC:      rd_data = DATA_W'(psc_q);
      REG_CNT:      rd_data = DATA_W'(tmr.cnt);
      REG_DEADTIME: begin
        rd_data[PWM_WIDTH-1:0]            = dt_rise_q;
        rd_data[DT_FALL_LSB +: PWM_WIDTH] = dt_fall_q;
      end
      REG_IER:      rd_data[ISR_PERIOD] = ier_q;
      REG_ISR:      rd_data[ISR_PERIOD] = isr_q;
      default: begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
          if (ch_hit && (ch_idx == ADDR_W'(i))) begin
            case (ch_reg)
              CH_CCR:  rd_data = DATA_W'(ccr_q[i]);
              CH_DUTY: rd_data = DATA_W'(duty_q[i]);
              default: ;
            endcase
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Read data valid with ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= rd_data;
    end
  end

  // ==================================================
  // Outputs to timebase and channels
  // ==================================================
  assign tmr.en     = gcr_q[GCR_EN];
  assign tmr.period = period_q;
  assign tmr.psc    = psc_q;
  assign out_en_o   = gcr_q[GCR_OUTEN];
  assign dt_rise_o  = dt_rise_q;
  assign dt_fall_o  = dt_fall_q;
  assign irq_o      = isr_q && ier_q;

  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      ch_cfg_o[i].en      = ccr_q[i][CCR_EN];
      ch_cfg_o[i].pol     = ccr_q[i][CCR_POL];
      ch_cfg_o[i].comp_en = ccr_q[i][CCR_COMPEN];
      ch_cfg_o[i].dt_en   = ccr_q[i][CCR_DTEN];
      ch_cfg_o[i].duty    = MAX_W'(duty_q[i]);  // Zero extend
    end
  end

endmodule

`default_nettype wire

// File: hw/pwm_timebase.sv
/*
 * PWM timebase
 * Prescaler and edge-aligned period counter with wrap pulse
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_timebase #(
  parameter int PWM_WIDTH = 16
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  pwm_timer_if.tb tmr
);

  logic [PWM_WIDTH-1:0] psc_cnt;   // Cycles since last tick
  logic                 last_cnt;  // Counter at end of period

  // Tick every PSC+1 cycles, >= covers a PSC lowered mid-count
  assign tmr.tick = tmr.en && (psc_cnt >= tmr.psc);

  // PERIOD of 0 wraps to all ones, full range count
  assign last_cnt = (tmr.cnt >= tmr.period - 1'b1);
  assign tmr.wrap = tmr.tick && last_cnt;  // One cycle, unregistered

  // ==================================================
  // Prescaler
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      psc_cnt <= '0;
    end else if (!tmr.en || tmr.tick) begin
      psc_cnt <= '0;  // Restart on tick or hold when stopped
    end else begin
      psc_cnt <= psc_cnt + 1'b1;
    end
  end

  // ==================================================
  // Period counter
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tmr.cnt <= '0;
    end else if (!tmr.en) begin
      tmr.cnt <= '0;  // Frozen at zero, channels see this
    end else if (tmr.wrap) begin
      tmr.cnt <= '0;
    end else if (tmr.tick) begin
      tmr.cnt <= tmr.cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/pwm_channel.sv
/*
 * PWM output channel
 * Duty compare, polarity, dead-time FSM and registered output gating
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_channel #(
  parameter int PWM_WIDTH = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  pwm_timer_if.chan            tmr,
  input  pwm_pkg::ch_cfg_t     cfg_i,
  input  logic [PWM_WIDTH-1:0] dt_rise_i,  // Ticks before turn on
  input  logic [PWM_WIDTH-1:0] dt_fall_i,  // Ticks before complement on
  input  logic                 out_en_i,
  output logic                 pwm_o,
  output logic                 pwm_n_o
);
  import pwm_pkg::*;

  logic                 cmp_hit;   // Counter below duty
  logic                 active;    // After enable and polarity
  dt_state_e            state_q;
  dt_state_e            state_d;
  logic [PWM_WIDTH-1:0] dt_cnt_q;  // Ticks spent in a wait state
  logic [PWM_WIDTH-1:0] dt_cnt_d;
  logic                 p_d;
  logic                 n_d;

  // DUTY >= PERIOD keeps the hit on all period
  assign cmp_hit = cfg_i.en && (MAX_W'(tmr.cnt) < cfg_i.duty);
  assign active  = cmp_hit ^ cfg_i.pol;

  // ==================================================
  // Dead-time FSM
  // ==================================================
  always_comb begin
    state_d  = state_q;
    dt_cnt_d = dt_cnt_q;
    if (!cfg_i.dt_en) begin
      // Track level directly, no wait states
      state_d  = active ? DT_ON : DT_OFF;
      dt_cnt_d = '0;
    end else begin
      case (state_q)
        DT_OFF: begin
          if (active) begin
            state_d  = DT_RISE;
            dt_cnt_d = '0;
          end
        end
        DT_RISE: begin
          if (!active) begin
            state_d = DT_OFF;  // Pulse shorter than dead-time
          end else if (tmr.tick) begin
            if (dt_cnt_q >= dt_rise_i) state_d = DT_ON;
            else dt_cnt_d = dt_cnt_q + 1'b1;
          end
        end
        DT_ON: begin
          if (!active) begin
            state_d  = DT_FALL;
            dt_cnt_d = '0;
          end
        end
        DT_FALL: begin
          if (active) begin
            state_d = DT_ON;  // Gap shorter than dead-time
          end else if (tmr.tick) begin
            if (dt_cnt_q >= dt_fall_i) state_d = DT_OFF;
            else dt_cnt_d = dt_cnt_q + 1'b1;
          end
        end
        default: state_d = DT_OFF;
      endcase
    end
  end

  // Both low in RISE and FALL
  assign p_d = (state_d == DT_ON);
  assign n_d = (state_d == DT_OFF) && cfg_i.comp_en;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= DT_OFF;
      dt_cnt_q <= '0;
      pwm_o    <= 1'b0;
      pwm_n_o  <= 1'b0;
    end else begin
      state_q  <= state_d;
      dt_cnt_q <= dt_cnt_d;
      pwm_o    <= out_en_i && p_d;  // One cycle behind cnt
      pwm_n_o  <= out_en_i && n_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/pwm_top.sv
/*
 * Multi-channel PWM timer
 * Wishbone classic register port, shared timebase, per-channel outputs
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_top #(
  parameter int NUM_CHANNELS = 8,
  parameter int PWM_WIDTH    = 16   // Up to MAX_W
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Wishbone classic slave
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [pwm_pkg::ADDR_W-1:0] adr_i,  // Word address
  input  logic [pwm_pkg::DATA_W-1:0] dat_i,
  output logic [pwm_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic                       irq_o,  // Period interrupt
  // PWM outputs
  output logic [NUM_CHANNELS-1:0]    pwm_o,
  output logic [NUM_CHANNELS-1:0]    pwm_n_o  // Complements
);
  import pwm_pkg::*;

  ch_cfg_t              ch_cfg [NUM_CHANNELS];
  logic [PWM_WIDTH-1:0] dt_rise;
  logic [PWM_WIDTH-1:0] dt_fall;
  logic                 out_en;

  pwm_timer_if #(.PWM_WIDTH(PWM_WIDTH)) tmr ();

  // ==================================================
  // Registers and timebase
  // ==================================================
  pwm_regs #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .PWM_WIDTH    (PWM_WIDTH)
  ) u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .dat_o     (dat_o),
    .ack_o     (ack_o),
    .irq_o     (irq_o),
    .tmr       (tmr.ctrl),
    .ch_cfg_o  (ch_cfg),
    .dt_rise_o (dt_rise),
    .dt_fall_o (dt_fall),
    .out_en_o  (out_en)
  );

  pwm_timebase #(.PWM_WIDTH(PWM_WIDTH)) u_timebase (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tmr    (tmr.tb)
  );

  // ==================================================
  // Channels
  // ==================================================
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gen_ch
    pwm_channel #(.PWM_WIDTH(PWM_WIDTH)) u_chan (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .tmr       (tmr.chan),
      .cfg_i     (ch_cfg[i]),
      .dt_rise_i (dt_rise),
      .dt_fall_i (dt_fall),
      .out_en_i  (out_en),
      .pwm_o     (pwm_o[i]),
      .pwm_n_o   (pwm_n_o[i])
    );
  end

endmodule

`default_nettype wire

// File: bench/pwm_sva.sv
/*
 * PWM timer assertions
 * Bus handshake on the register block, output exclusivity on channels
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic pwm_i,
  input logic pwm_n_i,
  input logic dt_en_i
);

  // ==================================================
  // Wishbone handshake
  // ==================================================
  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |=> !ack_i)
    else $error("ack_o stayed high for two cycles");

  ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |-> $past(cyc_i && stb_i))  // Ack one edge after request
    else $error("ack_o raised without a request");

  // ==================================================
  // Output exclusivity
  // ==================================================
  dt_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dt_en_i |-> !(pwm_i && pwm_n_i))
    else $error("pwm_o and pwm_n_o high together with dead-time on");

endmodule

bind pwm_regs pwm_sva u_regs_sva (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .cyc_i   (cyc_i),
  .stb_i   (stb_i),
  .ack_i   (ack_o),
  .pwm_i   (1'b0),  // No outputs here
  .pwm_n_i (1'b0),
  .dt_en_i (1'b0)
);

bind pwm_channel pwm_sva u_chan_sva (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .cyc_i   (1'b0),  // No bus here
  .stb_i   (1'b0),
  .ack_i   (1'b0),
  .pwm_i   (pwm_o),
  .pwm_n_i (pwm_n_o),
  .dt_en_i (cfg_i.dt_en)
);

`default_nettype wire

// File: bench/tb_pwm.sv
/*
 * PWM timer testbench
 * Random register, counter, duty, dead-time, interrupt and gate tests
 */
`timescale 1ns/1ns
`default_nettype none

module tb_pwm;
  import pwm_pkg::*;

  // ==================================================
  // Test sizing
  // ==================================================
  localparam int NUM_CH      = 8;
  localparam int PWM_W       = 16;
  localparam int DT_FALL_LSB = 16;   // Fall field in DEADTIME
  localparam int MAX_PER     = 19;   // Random PERIOD upper bound
  localparam int MAX_PSC     = 3;
  localparam int BUS_CYC     = 3;    // Drive, ack, idle
  localparam int ROUNDS      = 4;    // Duty and dead-time rounds
  localparam int PER_CYC     = (MAX_PER + 1) * (MAX_PSC + 1);  // Longest period
  localparam int CFG_OPS     = 5 + 2 * NUM_CH;                  // Writes per setup
  localparam int T_READ      = (4 * NUM_CH + 16) * BUS_CYC;
  localparam int T_CNT       = 30 * BUS_CYC;
  localparam int T_DUTY      = ROUNDS * (CFG_OPS * BUS_CYC + 2 * PER_CYC);
  localparam int T_DT        = ROUNDS * (CFG_OPS * BUS_CYC + 3 * PER_CYC);
  localparam int T_IRQ       = 12 * BUS_CYC + 2 * PER_CYC;
  localparam int T_GATE      = CFG_OPS * BUS_CYC + 2 * PER_CYC;
  localparam int T_TOTAL     = 8 + T_READ + T_CNT + T_DUTY + T_DT + T_IRQ + T_GATE;

  localparam logic [DATA_W-1:0] W_MASK  = {{(DATA_W-PWM_W){1'b0}}, {PWM_W{1'b1}}};
  localparam logic [DATA_W-1:0] GCR_CNT = DATA_W'(1 << GCR_EN);  // Count, outputs gated
  localparam logic [DATA_W-1:0] GCR_RUN = DATA_W'((1 << GCR_EN) | (1 << GCR_OUTEN));

  logic              clk;
  logic              rst_n;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [ADDR_W-1:0] adr;
  logic [DATA_W-1:0] dat_w;
  logic [DATA_W-1:0] dat_r;
  logic              ack;
  logic              irq;
  logic [NUM_CH-1:0] pwm;
  logic [NUM_CH-1:0] pwm_n;
  integer            seed;

  // Model of the current setup
  int                period_m;
  int                psc_m;
  int                duty_m [NUM_CH];
  logic [NUM_CH-1:0] pol_m;
  logic [NUM_CH-1:0] comp_m;

  pwm_top #(
    .NUM_CHANNELS (NUM_CH),
    .PWM_WIDTH    (PWM_W)
  ) DUT (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .cyc_i   (cyc),
    .stb_i   (stb),
    .we_i    (we),
    .adr_i   (adr),
    .dat_i   (dat_w),
    .dat_o   (dat_r),
    .ack_o   (ack),
    .irq_o   (irq),
    .pwm_o   (pwm),
    .pwm_n_o (pwm_n)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  // ==================================================
  // Reporting and bus helpers
  // ==================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input string name, input logic [DATA_W-1:0] exp,
                       input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  function automatic int pick(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  function automatic logic [ADDR_W-1:0] ch_addr(input int ch, input ch_reg_e r);
    return ADDR_W'(CH_BASE + CH_STRIDE * ch + int'(r));
  endfunction

  // One classic cycle, sampled on falling edges
  task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] q);
    int waited;
    waited = 0;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    @(negedge clk);
    while (!ack && waited < 8) begin
      waited++;
      @(negedge clk);
    end
    if (!ack) begin
      fail_run($sformatf("No ack from the DUT for address %0d", a));
    end else begin
      q   = dat_r;  // Valid while ack is high
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
    end
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] q);
    bus_access(1'b0, a, '0, q);
  endtask

  task automatic set_timebase(input int per_lo);
    period_m = pick(per_lo, MAX_PER);
    psc_m    = pick(0, MAX_PSC);
    reg_write(REG_PERIOD, DATA_W'(period_m));
    reg_write(REG_PSC, DATA_W'(psc_m));
  endtask

  // Random duty and polarity on every channel, complement forced with dead-time
  task automatic setup_channels(input int dlo, input int dhi, input logic dt);
    logic [DATA_W-1:0] ccr;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      duty_m[ch]      = pick(dlo, dhi);
      pol_m[ch]       = (pick(0, 1) == 1);
      comp_m[ch]      = dt || (pick(0, 1) == 1);
      ccr             = '0;
      ccr[CCR_EN]     = 1'b1;
      ccr[CCR_POL]    = pol_m[ch];
      ccr[CCR_COMPEN] = comp_m[ch];
      ccr[CCR_DTEN]   = dt;
      reg_write(ch_addr(ch, CH_CCR), ccr);
      reg_write(ch_addr(ch, CH_DUTY), DATA_W'(duty_m[ch]));
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_readback();
    logic [ADDR_W-1:0] addr    [4];
    logic [DATA_W-1:0] mask    [4];
    logic [ADDR_W-1:0] unknown [4];
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] q;
    addr    = '{REG_PERIOD, REG_PSC, REG_DEADTIME, REG_IER};
    mask    = '{W_MASK, W_MASK, 32'hffff_ffff, 32'h1};  // Both dead-time halves
    unknown = '{6'd7, 6'd15, 6'd32, 6'd63};
    for (int i = 0; i < 4; i++) begin
      v = $random(seed);
      reg_write(addr[i], v);
      reg_read(addr[i], q);
      check($sformatf("readback reg %0d", addr[i]), v & mask[i], q);
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      v = $random(seed);
      reg_write(ch_addr(ch, CH_CCR), v);
      reg_read(ch_addr(ch, CH_CCR), q);
      check($sformatf("readback ccr%0d", ch), v & 32'hf, q);
      v = $random(seed);
      reg_write(ch_addr(ch, CH_DUTY), v);
      reg_read(ch_addr(ch, CH_DUTY), q);
      check($sformatf("readback duty%0d", ch), v & W_MASK, q);
    end
    for (int i = 0; i < 4; i++) begin
      reg_read(unknown[i], q);
      check($sformatf("unknown addr %0d", unknown[i]), '0, q);
    end
  endtask

  task automatic test_counter();
    logic [DATA_W-1:0] q;
    set_timebase(4);
    reg_write(REG_GCR, GCR_CNT);
    repeat (20) begin
      reg_read(REG_CNT, q);
      check("counter in range", 32'd1, DATA_W'(q < DATA_W'(period_m)));
    end
    reg_write(REG_PSC, 32'hffff);  // Slow ticks, count holds still
    reg_read(REG_CNT, q);
    reg_write(REG_CNT, ~q);        // Read only, value far past PERIOD
    reg_read(REG_CNT, q);
    check("counter write ignored", 32'd1, DATA_W'(q < DATA_W'(period_m)));
    reg_write(REG_GCR, '0);
    reg_read(REG_CNT, q);
    check("counter stopped", '0, q);
  endtask

  task automatic test_duty(input int round);
    int win;
    int exp_hi;
    int hi_cnt [NUM_CH];
    reg_write(REG_GCR, '0);
    set_timebase(4);
    setup_channels(0, period_m + 3, 1'b0);  // Some duties past PERIOD
    reg_write(REG_GCR, GCR_RUN);
    win = period_m * (psc_m + 1);
    for (int ch = 0; ch < NUM_CH; ch++) hi_cnt[ch] = 0;
    @(negedge clk);  // Outputs now follow the running counter
    repeat (win) begin
      @(negedge clk);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (pwm[ch]) hi_cnt[ch]++;
      end
      check($sformatf("complement round %0d", round), DATA_W'(~pwm & comp_m),
            DATA_W'(pwm_n));
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      exp_hi = (duty_m[ch] < period_m ? duty_m[ch] : period_m) * (psc_m + 1);
      if (pol_m[ch]) exp_hi = win - exp_hi;  // Active low
      check($sformatf("duty round %0d ch%0d", round, ch), DATA_W'(exp_hi),
            DATA_W'(hi_cnt[ch]));
    end
  endtask

  task automatic test_deadtime(input int round);
    int                win;
    logic [DATA_W-1:0] dt;
    logic [NUM_CH-1:0] p_hi;
    logic [NUM_CH-1:0] p_lo;
    logic [NUM_CH-1:0] n_hi;
    logic [NUM_CH-1:0] n_lo;
    reg_write(REG_GCR, '0);
    set_timebase(8);
    dt = '0;
    dt[PWM_W-1:0]              = PWM_W'(pick(0, 1));
    dt[DT_FALL_LSB +: PWM_W]   = PWM_W'(pick(0, 1));
    reg_write(REG_DEADTIME, dt);
    setup_channels(3, period_m - 3, 1'b1);  // On and off both outlast dead-time
    reg_write(REG_GCR, GCR_RUN);
    win  = period_m * (psc_m + 1);
    p_hi = '0;
    p_lo = '0;
    n_hi = '0;
    n_lo = '0;
    repeat (2 * win) begin
      @(negedge clk);
      check($sformatf("deadtime overlap round %0d", round), '0, DATA_W'(pwm & pwm_n));
      p_hi |= pwm;
      p_lo |= ~pwm;
      n_hi |= pwm_n;
      n_lo |= ~pwm_n;
    end
    check($sformatf("deadtime toggle round %0d", round), DATA_W'({NUM_CH{1'b1}}),
          DATA_W'(p_hi & p_lo & n_hi & n_lo));
  endtask

  task automatic test_irq();
    int                win;
    logic [DATA_W-1:0] q;
    reg_write(REG_GCR, '0);
    reg_write(REG_IER, '0);
    set_timebase(4);
    reg_write(REG_ISR, DATA_W'(1 << ISR_PERIOD));  // Drop stale status
    reg_read(REG_ISR, q);
    check("isr cleared before run", '0, q);
    reg_write(REG_GCR, GCR_CNT);
    win = period_m * (psc_m + 1);
    repeat (win + 4) @(negedge clk);  // One full period plus margin
    reg_write(REG_GCR, '0);
    reg_read(REG_ISR, q);
    check("isr after period", 32'd1, q);
    check("irq masked", '0, DATA_W'(irq));
    reg_write(REG_IER, 32'd1);
    check("irq enabled", 32'd1, DATA_W'(irq));
    reg_write(REG_ISR, DATA_W'(1 << ISR_PERIOD));
    reg_read(REG_ISR, q);
    check("isr after clear", '0, q);
    check("irq after clear", '0, DATA_W'(irq));
  endtask

  task automatic test_gate();
    int win;
    reg_write(REG_GCR, '0);
    set_timebase(4);
    setup_channels(1, period_m - 1, 1'b0);
    reg_write(REG_GCR, GCR_CNT);  // Counting, gate closed
    win = period_m * (psc_m + 1);
    repeat (win + 1) begin
      @(negedge clk);
      check("gate pwm_o", '0, DATA_W'(pwm));
      check("gate pwm_n_o", '0, DATA_W'(pwm_n));
    end
  endtask

  // ==================================================
  // Watchdog and main sequence
  // ==================================================
  initial begin
    repeat (4 * T_TOTAL) @(posedge clk);
    fail_run("Watchdog expired before the tests finished");
  end

  initial begin
    seed  = 32'he998;
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check("reset outputs", '0, DATA_W'({ack, irq, pwm, pwm_n}));
    test_readback();
    test_counter();
    for (int r = 0; r < ROUNDS; r++) test_duty(r);
    for (int r = 0; r < ROUNDS; r++) test_deadtime(r);
    test_irq();
    test_gate();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/pwm_pkg.sv
hw/pwm_timer_if.sv
hw/pwm_regs.sv
hw/pwm_timebase.sv
hw/pwm_channel.sv
hw/pwm_top.sv
bench/pwm_sva.sv
bench/tb_pwm.sv

// File: run_sim.sh
#!/bin/sh
# Build the PWM timer testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
PASS_LINE="Simulation passed"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_pwm -Mdir "$BUILD_DIR" -o tb_pwm
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_pwm" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -qx "$PASS_LINE" "$LOG"; then
  echo "Run result: PASS"
  exit 0
else
  echo "Run result: FAIL"
  exit 1
fi
